// File: rtl/taylor_pkg.sv
`default_nettype none

package taylor_pkg;

	// ==================================================
	// Widths and counts
	// ==================================================
	localparam int SAMPLE_W = 19;
	localparam int RESULT_W = 28;
	localparam int FRAC_BITS = 15;
	localparam int TAG_W = 8;
	localparam int PROD_W = RESULT_W + SAMPLE_W;

	localparam int NUM_CORES = 4;
	localparam int CORE_IDX_W = $clog2(NUM_CORES);
	localparam int STAGGER_CYCLES = 20;
	localparam int STAGGER_CNT_W = $clog2(STAGGER_CYCLES);

	// ==================================================
	// Series coefficients
	// ==================================================
	localparam int NUM_COEFFS = 6;
	localparam int STEP_W = $clog2(NUM_COEFFS + 1);

	// exp(x) in Q.15, x^5 term first.
	localparam logic signed [RESULT_W-1:0] SERIES_COEFFS [NUM_COEFFS] = '{
		28'sd273,
		28'sd1365,
		28'sd5461,
		28'sd16384,
		28'sd32768,
		28'sd32768
	};

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic signed [SAMPLE_W-1:0] value;
	} sample_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic signed [RESULT_W-1:0] value;
	} result_t;

endpackage

`default_nettype wire

// File: rtl/core_start_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_start_sequencer
	import taylor_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	output logic [NUM_CORES-1:0] core_enable
);

	logic [STAGGER_CNT_W-1:0] cycle_cnt;
	logic [CORE_IDX_W-1:0]    release_idx;

	// One core released per interval, counting frozen once all are up.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle_cnt   <= '0;
			release_idx <= '0;
			core_enable <= '0;
		end else if (!(&core_enable)) begin
			if (cycle_cnt == STAGGER_CNT_W'(STAGGER_CYCLES - 1)) begin
				cycle_cnt                <= '0;
				core_enable[release_idx] <= 1'b1;
				release_idx              <= release_idx + 1'b1;
			end else begin
				cycle_cnt <= cycle_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/sample_intake.sv
`timescale 1ns/1ps
`default_nettype none

module sample_intake
	import taylor_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_req,
	input  sample_t              in_sample,
	output logic                 in_ack,
	input  logic [NUM_CORES-1:0] core_enable,
	input  logic [NUM_CORES-1:0] idle,
	output logic [NUM_CORES-1:0] start,
	output sample_t              dispatch_sample
);

	typedef enum logic [1:0] {
		IN_IDLE,
		IN_DISPATCH,
		IN_ACK
	} in_state_t;

	in_state_t            state;
	logic [NUM_CORES-1:0] free;
	logic [NUM_CORES-1:0] pick;
	logic                 accept;

	// Lowest-numbered enabled and idle core.
	assign free   = core_enable & idle;
	assign pick   = free & (~free + 1'b1);
	assign accept = (state == IN_IDLE) && in_req && (|free);

	assign in_ack = (state == IN_ACK);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IN_IDLE;
			start <= '0;
		end else begin
			start <= '0;
			case (state)
				IN_IDLE: begin
					if (accept) begin
						start <= pick;
						state <= IN_DISPATCH;
					end
				end
				IN_DISPATCH: state <= IN_ACK;
				// Hold ack until the producer releases req.
				IN_ACK: if (!in_req) state <= IN_IDLE;
				default: state <= IN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dispatch_sample <= in_sample;
	end

endmodule

`default_nettype wire

// File: rtl/series_core.sv
`timescale 1ns/1ps
`default_nettype none

module series_core
	import taylor_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    start,
	input  sample_t sample,
	input  logic    take,
	output logic    idle,
	output logic    done,
	output result_t result
);

	logic                       busy;
	logic [STEP_W-1:0]          step;
	sample_t                    sample_q;
	logic signed [RESULT_W-1:0] acc;
	logic signed [PROD_W-1:0]   product;
	logic signed [PROD_W-1:0]   shifted;
	logic signed [RESULT_W-1:0] acc_next;
	logic                       launch;

	assign idle   = !busy && !done;
	assign launch = start && idle;

	// ==================================================
	// Horner step
	// ==================================================
	assign product  = acc * sample_q.value;
	assign shifted  = product >>> FRAC_BITS;
	// Wraps at the result width.
	assign acc_next = shifted[RESULT_W-1:0] + SERIES_COEFFS[step];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else if (launch) begin
			busy <= 1'b1;
			step <= STEP_W'(1);
		end else if (busy) begin
			if (step == STEP_W'(NUM_COEFFS - 1)) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			step <= step + 1'b1;
		end else if (done && take) begin
			done <= 1'b0;
		end
	end

	// Accumulator seeded with the highest-order coefficient.
	always_ff @(posedge clk) begin
		if (launch) begin
			sample_q <= sample;
			acc      <= SERIES_COEFFS[0];
		end else if (busy) begin
			acc <= acc_next;
		end
	end

	assign result = '{tag: sample_q.tag, value: acc};

endmodule

`default_nettype wire

// File: rtl/result_collector.sv
`timescale 1ns/1ps
`default_nettype none

module result_collector
	import taylor_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [NUM_CORES-1:0] done,
	input  result_t              core_results [NUM_CORES],
	output logic [NUM_CORES-1:0] take,
	output logic                 out_req,
	input  logic                 out_ack,
	output result_t              out_result
);

	typedef enum logic [1:0] {
		OUT_IDLE,
		OUT_REQ,
		OUT_RELEASE
	} out_state_t;

	out_state_t           state;
	logic [NUM_CORES-1:0] pick;
	result_t              pick_result;
	logic                 load;

	// Lowest-numbered finished core wins.
	assign pick = done & (~done + 1'b1);

	always_comb begin
		pick_result = core_results[0];
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (done[i])
				pick_result = core_results[i];
		end
	end

	assign load    = (state == OUT_IDLE) && !out_ack && (|done);
	assign out_req = (state == OUT_REQ);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= OUT_IDLE;
			take  <= '0;
		end else begin
			take <= '0;
			case (state)
				OUT_IDLE: begin
					if (load) begin
						take  <= pick;
						state <= OUT_REQ;
					end
				end
				OUT_REQ: if (out_ack) state <= OUT_RELEASE;
				// Wait for the consumer to drop ack.
				OUT_RELEASE: if (!out_ack) state <= OUT_IDLE;
				default: state <= OUT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			out_result <= pick_result;
	end

endmodule

`default_nettype wire

// File: rtl/multicore_top.sv
`timescale 1ns/1ps
`default_nettype none

module multicore_top
	import taylor_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    in_req,
	input  sample_t in_sample,
	output logic    in_ack,
	output logic    out_req,
	input  logic    out_ack,
	output result_t out_result
);

	logic [NUM_CORES-1:0] core_enable;
	logic [NUM_CORES-1:0] start;
	logic [NUM_CORES-1:0] idle;
	logic [NUM_CORES-1:0] done;
	logic [NUM_CORES-1:0] take;
	sample_t              dispatch_sample;
	result_t              core_results [NUM_CORES];

	// ==================================================
	// Input side
	// ==================================================
	core_start_sequencer u_sequencer (
		.clk         (clk),
		.arst_n      (arst_n),
		.core_enable (core_enable)
	);

	sample_intake u_intake (
		.clk             (clk),
		.arst_n          (arst_n),
		.in_req          (in_req),
		.in_sample       (in_sample),
		.in_ack          (in_ack),
		.core_enable     (core_enable),
		.idle            (idle),
		.start           (start),
		.dispatch_sample (dispatch_sample)
	);

	// ==================================================
	// Cores
	// ==================================================
	for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
		series_core u_core (
			.clk    (clk),
			.arst_n (arst_n),
			.start  (start[g]),
			.sample (dispatch_sample),
			.take   (take[g]),
			.idle   (idle[g]),
			.done   (done[g]),
			.result (core_results[g])
		);
	end

	result_collector u_collector (
		.clk          (clk),
		.arst_n       (arst_n),
		.done         (done),
		.core_results (core_results),
		.take         (take),
		.out_req      (out_req),
		.out_ack      (out_ack),
		.out_result   (out_result)
	);

endmodule

`default_nettype wire

// File: testbench/series_model.svh
`ifndef SERIES_MODEL_SVH
`define SERIES_MODEL_SVH

// Keeps the low RESULT_W bits as a signed value.
function automatic longint wrap_result(input longint v);
	longint m;
	m = v & ((longint'(1) << RESULT_W) - 1);
	if (m[RESULT_W-1])
		m = m - (longint'(1) << RESULT_W);
	return m;
endfunction

// Horner evaluation of the series for one Q.15 sample.
function automatic logic [RESULT_W-1:0] series_expected(
	input logic signed [SAMPLE_W-1:0] x
);
	longint acc;
	longint xs;
	acc = longint'(SERIES_COEFFS[0]);
	xs  = longint'(x);
	for (int k = 1; k < NUM_COEFFS; k++) begin
		// Exact product, arithmetic shift, then wrap.
		acc = wrap_result((acc * xs) >>> FRAC_BITS);
		acc = wrap_result(acc + longint'(SERIES_COEFFS[k]));
	end
	return acc[RESULT_W-1:0];
endfunction

`endif

// File: testbench/tb_multicore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_multicore
	import taylor_pkg::*;
();

	`include "series_model.svh"

	localparam int NUM_SAMPLES    = 3 + 24 + NUM_CORES + 2 + 10;
	localparam int STALL_CYCLES   = 80;
	localparam int DRAIN_CYCLES   = 200;
	localparam int TIMEOUT_CYCLES = NUM_SAMPLES * 40 + STALL_CYCLES
		+ NUM_CORES * STAGGER_CYCLES;

	logic    clk, arst_n, in_req, in_ack, out_req, out_ack, stall, burst_done;
	logic    prev_in_req, prev_in_ack, prev_out_req, prev_out_ack;
	sample_t in_sample;
	result_t out_result, prev_result;
	int      cyc = 0, ack_count = 0, next_tag = 0, recv_count = 0;
	int      value_errors = 0, proto_errors = 0, other_errors = 0;
	logic [RESULT_W-1:0] expected [logic [TAG_W-1:0]];
	bit                  received [logic [TAG_W-1:0]];

	multicore_top DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_req     (in_req),
		.in_sample  (in_sample),
		.in_ack     (in_ack),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) if (arst_n) cyc <= cyc + 1;

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_value(input logic signed [SAMPLE_W-1:0] v);
		in_sample.tag   = TAG_W'(next_tag);
		in_sample.value = v;
		expected[in_sample.tag] = series_expected(v);
		next_tag++;
		in_req = 1'b1;
		do next_cycle(); while (!in_ack);
		ack_count++;
		in_req = 1'b0;
		do next_cycle(); while (in_ack);
	endtask

	task automatic send_random(input int n);
		repeat (n) send_value(SAMPLE_W'($urandom));
	endtask

	task automatic check_result(input result_t r);
		assert (expected.exists(r.tag)) else begin
			if (received.exists(r.tag))
				$display("Result for tag 0x%h came back a second time", r.tag);
			else
				$display("Result carries tag 0x%h, which was never sent", r.tag);
			other_errors++;
		end
		if (expected.exists(r.tag)) begin
			assert (r.value == expected[r.tag]) else begin
				$display("ERROR out_result.value tag=0x%h got=0x%h exp=0x%h",
					r.tag, r.value, expected[r.tag]);
				value_errors++;
			end
			expected.delete(r.tag);
			received[r.tag] = 1'b1;
			recv_count++;
		end
	endtask

	task automatic print_summary();
		$display("Sent %0d, received %0d, errors: value %0d, protocol %0d, other %0d",
			next_tag, recv_count, value_errors, proto_errors, other_errors);
	endtask

	// Consumer with a random ack delay; holds off entirely while stalled.
	initial begin : consumer
		@(posedge arst_n);
		forever begin
			next_cycle();
			if (out_req && !stall) begin
				repeat ($urandom_range(0, 4)) next_cycle();
				check_result(out_result);
				out_ack = 1'b1;
				do next_cycle(); while (out_req);
				// Ack lingers a few cycles after req falls.
				repeat ($urandom_range(0, 3)) next_cycle();
				out_ack = 1'b0;
			end
		end
	end

	// ==================================================
	// Handshake monitor
	// ==================================================
	always @(negedge clk) begin
		if (arst_n) begin
			assert (!(in_ack && cyc < STAGGER_CYCLES)) else begin
				$display("in_ack rose %0d cycles after reset release, before any core was up",
					cyc);
				proto_errors++;
			end
			assert (!(in_ack && !prev_in_ack && !prev_in_req)) else begin
				$display("in_ack rose while in_req was low");
				proto_errors++;
			end
			assert (!(out_req && !prev_out_req && prev_out_ack)) else begin
				$display("out_req rose while out_ack was still high");
				proto_errors++;
			end
			assert (!(out_req && prev_out_req && out_result != prev_result)) else begin
				$display("ERROR out_result changed during out_req: 0x%h -> 0x%h",
					prev_result, out_result);
				proto_errors++;
			end
		end
		prev_in_req  = in_req;
		prev_in_ack  = in_ack;
		prev_out_req = out_req;
		prev_out_ack = out_ack;
		prev_result  = out_result;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES + 3) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		other_errors++;
		print_summary();
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int stall_base;
		void'($urandom(86));
		arst_n     = 1'b0;
		in_req     = 1'b0;
		in_sample  = '0;
		out_ack    = 1'b0;
		stall      = 1'b0;
		burst_done = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Zero, largest positive and most negative samples first.
		send_value('0);
		send_value({1'b0, {(SAMPLE_W-1){1'b1}}});
		send_value({1'b1, {(SAMPLE_W-1){1'b0}}});
		send_random(24);

		// ==================================================
		// Back-pressure with every core up
		// ==================================================
		do next_cycle();
		while (expected.num() != 0 || out_req
			|| cyc < NUM_CORES * STAGGER_CYCLES + 2);
		stall      = 1'b1;
		stall_base = ack_count;
		fork
			begin
				send_random(NUM_CORES + 2);
				burst_done = 1'b1;
			end
		join_none
		repeat (STALL_CYCLES) next_cycle();
		// One result per core, plus one parked in the collector output register.
		assert (ack_count - stall_base == NUM_CORES + 1) else begin
			$display("%0d samples acknowledged during the stall, expected %0d",
				ack_count - stall_base, NUM_CORES + 1);
			other_errors++;
		end
		stall = 1'b0;
		wait (burst_done);
		send_random(10);

		for (int i = 0; i < DRAIN_CYCLES && (expected.num() != 0 || out_req); i++)
			next_cycle();
		assert (expected.num() == 0) else begin
			foreach (expected[t])
				$display("No result came back for tag 0x%h", t);
			other_errors += expected.num();
		end

		print_summary();
		if (value_errors + proto_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+testbench
rtl/taylor_pkg.sv
rtl/core_start_sequencer.sv
rtl/sample_intake.sv
rtl/series_core.sv
rtl/result_collector.sv
rtl/multicore_top.sv
testbench/tb_multicore.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multicore series testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_multicore \
	-f filelist.f -o sim_multicore
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_multicore)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'Result: PASSED'; then
	exit 0
fi
exit 1
